// ==== flist.f ====
+incdir+verif
design/eva_npa_pkg.sv
design/dram_hash.sv
design/eva_to_npa.sv
design/endpoint_cfg.sv
design/npa_issue_reg.sv
design/npa_xlate_top.sv
verif/tb_npa_xlate.sv

// ==== verif/npa_ref_model.svh ====
// expected npa for a given eva and endpoint config, included inside the testbench module
`ifndef NPA_REF_MODEL_SVH
`define NPA_REF_MODEL_SVH

  // dram striping, word address w = eva[30:2]
  function automatic eva_npa_pkg::npa_s dram_stripe_npa(input eva_npa_pkg::eva_t eva,
                                                        input eva_npa_pkg::pod_x_t pod_x,
                                                        input eva_npa_pkg::pod_y_t pod_y,
                                                        input int rows);
    logic [28:0]         w;
    logic [3:0]          off;
    logic [3:0]          col;
    logic [28:0]         set_idx;
    logic [3:0]          side_pod_y;
    int                  sel_bits;
    int                  sel;
    int                  k;
    eva_npa_pkg::npa_s   r;
    w        = eva[30:2];
    off      = w[3:0];
    col      = w[7:4];
    // selector above the column, power-of-two wide
    sel_bits = $clog2(2 * rows);
    sel      = int'(w[28:8]) % (2 * rows);
    k        = sel >> 1;
    set_idx  = w >> (8 + sel_bits);
    r.x_cord = {pod_x, col};
    if (sel % 2 == 1) begin
      // south side, one pod below, row k counts from the top
      side_pod_y = pod_y + 4'd1;
      r.y_cord   = {side_pod_y, 3'(k)};
    end else begin
      // north side, one pod above, row k counts from the bottom
      side_pod_y = pod_y - 4'd1;
      r.y_cord   = {side_pod_y, 3'(7 - k)};
    end
    r.epa = (eva_npa_pkg::epa_t'(set_idx) << 4) | eva_npa_pkg::epa_t'(off);
    return r;
  endfunction

  // overflowed dmem window reshuffle into a dram eva
  function automatic eva_npa_pkg::eva_t overflow_permute(input eva_npa_pkg::eva_t eva);
    eva_npa_pkg::eva_t p;
    // start from a copy, then overwrite the moved fields
    p        = eva;
    p[31]    = 1'b1;
    p[9:6]   = eva[21:18];
    p[21:18] = eva[14:11];
    p[14:11] = eva[9:6];
    p[10]    = eva[26];
    p[26]    = eva[10];
    return p;
  endfunction

  // full classification, dram first then global, tile group, invalid
  function automatic eva_npa_pkg::npa_s expected_npa(input eva_npa_pkg::eva_t eva,
                                                     input eva_npa_pkg::endpoint_cfg_s cfg,
                                                     input int rows,
                                                     output logic invalid);
    logic [15:0]       addr;
    logic [3:0]        xs;
    logic [2:0]        ys;
    eva_npa_pkg::npa_s r;
    r       = '0;
    invalid = 1'b0;
    addr    = eva[15:0];
    if (eva[31]) begin
      r = dram_stripe_npa(eva, cfg.pod_x, cfg.pod_y, rows);
    end else if (eva[31:30] == 2'b01) begin
      r.x_cord = eva[22:16];
      r.y_cord = eva[29:23];
      r.epa    = eva_npa_pkg::epa_t'(addr);
    end else if (eva[31:29] == 3'b001) begin
      if (addr >= 16'h0100 && addr <= 16'hFCFF) begin
        r = dram_stripe_npa(overflow_permute(eva), cfg.pod_x, cfg.pod_y, rows);
      end else begin
        // origin add wraps inside the pod
        xs       = eva[19:16] + cfg.tgo_x;
        ys       = eva[25:23] + cfg.tgo_y;
        r.x_cord = {cfg.pod_x, xs};
        r.y_cord = {cfg.pod_y, ys};
        r.epa    = eva_npa_pkg::epa_t'(addr[9:0]);
      end
    end else begin
      invalid = 1'b1;
    end
    return r;
  endfunction

`endif

// ==== verif/tb_npa_xlate.sv ====
// self-checking testbench for the endpoint address path, compiled with the file list
`timescale 1ns/1ps

module tb_npa_xlate;

  localparam int num_vcache_rows_lp = 1;
  localparam int num_entries_lp     = 20;
  localparam int num_random_lp      = 32;
  // at most cfg write, request and idle per row or draw
  localparam int cycle_limit_lp = 4 + 3 * num_entries_lp + 3 * num_random_lp + 50;

  typedef struct packed {
    logic                       cfg_we;
    eva_npa_pkg::endpoint_cfg_s cfg;
    eva_npa_pkg::eva_t          eva;
    logic                       b2b;
  } stim_s;

  logic                       clk_i;
  logic                       rst_i;
  logic                       cfg_we_i;
  eva_npa_pkg::endpoint_cfg_s cfg_data_i;
  logic                       req_i;
  eva_npa_pkg::eva_t          eva_i;
  logic                       res_v_o;
  eva_npa_pkg::npa_s          res_o;
  logic                       res_invalid_o;

  stim_s                      stim_table [num_entries_lp];
  // config as the dut should see it for the next request
  eva_npa_pkg::endpoint_cfg_s model_cfg;
  eva_npa_pkg::npa_s          exp_npa_q [$];
  logic                       exp_inv_q [$];
  eva_npa_pkg::eva_t          exp_eva_q [$];
  logic                       req_seen;
  int                         sent_cnt;
  int                         seen_cnt;
  int                         cycle_cnt;
  int                         seed;

  `include "npa_ref_model.svh"

  npa_xlate_top #(
    .num_vcache_rows_p(num_vcache_rows_lp)
  ) dut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .cfg_we_i     (cfg_we_i),
    .cfg_data_i   (cfg_data_i),
    .req_i        (req_i),
    .eva_i        (eva_i),
    .res_v_o      (res_v_o),
    .res_o        (res_o),
    .res_invalid_o(res_invalid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic check_flag(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, act, exp);
      $display("TEST FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic check_npa(input eva_npa_pkg::npa_s act, input eva_npa_pkg::npa_s exp,
                           input string what);
    if (act !== exp) begin
      $display("CHECK FAILED at %0t: %s got x=%h y=%h epa=%h, expected x=%h y=%h epa=%h",
               $time, what, act.x_cord, act.y_cord, act.epa, exp.x_cord, exp.y_cord, exp.epa);
      $display("TEST FAILED");
      $fatal(1, "npa mismatch");
    end
  endtask

  function automatic eva_npa_pkg::endpoint_cfg_s make_cfg(input eva_npa_pkg::x_sub_t tgo_x,
                                                          input eva_npa_pkg::y_sub_t tgo_y,
                                                          input eva_npa_pkg::pod_x_t pod_x,
                                                          input eva_npa_pkg::pod_y_t pod_y);
    eva_npa_pkg::endpoint_cfg_s c;
    c.tgo_x = tgo_x;
    c.tgo_y = tgo_y;
    c.pod_x = pod_x;
    c.pod_y = pod_y;
    return c;
  endfunction

  task automatic set_row(input int idx, input logic we, input eva_npa_pkg::endpoint_cfg_s cfg,
                         input eva_npa_pkg::eva_t eva, input logic b2b);
    stim_table[idx].cfg_we = we;
    stim_table[idx].cfg    = cfg;
    stim_table[idx].eva    = eva;
    stim_table[idx].b2b    = b2b;
  endtask

  task automatic fill_table();
    eva_npa_pkg::endpoint_cfg_s none;
    none = '0;
    // dram, north and south, pod_y wrap at both ends
    set_row(0, 1'b1, make_cfg(4'd0, 3'd0, 3'd2, 4'd5), 32'h8000_0000, 1'b0);
    set_row(1, 1'b0, none, 32'h8000_0124, 1'b1);
    set_row(2, 1'b0, none, 32'hC123_4567, 1'b1);
    set_row(3, 1'b0, none, 32'h8000_0400, 1'b0);
    set_row(4, 1'b1, make_cfg(4'd0, 3'd0, 3'd7, 4'd0), 32'h8000_0000, 1'b1);
    set_row(5, 1'b1, make_cfg(4'd0, 3'd0, 3'd1, 4'd15), 32'h8000_07F0, 1'b0);
    // global
    set_row(6, 1'b0, none, 32'h5A3C_1234, 1'b1);
    set_row(7, 1'b0, none, 32'h7FFF_FFFF, 1'b0);
    // tile group around both window edges
    set_row(8, 1'b1, make_cfg(4'd14, 3'd6, 3'd3, 4'd9), 32'h2205_00FF, 1'b0);
    set_row(9, 1'b0, none, 32'h2205_0100, 1'b1);
    set_row(10, 1'b0, none, 32'h2205_FCFF, 1'b1);
    set_row(11, 1'b0, none, 32'h2205_FD00, 1'b0);
    set_row(12, 1'b0, none, 32'h3FFF_FFFF, 1'b0);
    // new origin, same eva as row 8
    set_row(13, 1'b1, make_cfg(4'd1, 3'd1, 3'd3, 4'd9), 32'h2205_00FF, 1'b0);
    // mixed kinds back to back, invalid among them
    set_row(14, 1'b0, none, 32'h2345_6789, 1'b1);
    set_row(15, 1'b0, none, 32'h0000_1234, 1'b1);
    set_row(16, 1'b0, none, 32'h8765_4321, 1'b1);
    set_row(17, 1'b0, none, 32'h1FFF_FFFF, 1'b1);
    set_row(18, 1'b0, none, 32'h4123_0042, 1'b1);
    set_row(19, 1'b0, none, 32'h2000_0000, 1'b0);
  endtask

  // called at 1 ns past a rising edge, leaves the same way
  task automatic apply_entry(input stim_s s);
    logic inv;
    if (s.cfg_we) begin
      cfg_we_i   = 1'b1;
      cfg_data_i = s.cfg;
      model_cfg  = s.cfg;
      @(posedge clk_i);
      #1;
      cfg_we_i = 1'b0;
    end
    req_i = 1'b1;
    eva_i = s.eva;
    exp_npa_q.push_back(expected_npa(s.eva, model_cfg, num_vcache_rows_lp, inv));
    exp_inv_q.push_back(inv);
    exp_eva_q.push_back(s.eva);
    sent_cnt++;
    @(posedge clk_i);
    #1;
    req_i = 1'b0;
    if (!s.b2b) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // request seen at this edge owes a result by the next one
  always @(posedge clk_i) begin
    req_seen = req_i;
  end

  always @(negedge clk_i) begin : check_results
    eva_npa_pkg::npa_s exp_npa;
    logic              exp_inv;
    eva_npa_pkg::eva_t exp_eva;
    if (!rst_i) begin
      check_flag(res_v_o, req_seen, "res_v_o");
      if (req_seen) begin
        exp_npa = exp_npa_q.pop_front();
        exp_inv = exp_inv_q.pop_front();
        exp_eva = exp_eva_q.pop_front();
        check_npa(res_o, exp_npa, $sformatf("res_o for eva %h", exp_eva));
        check_flag(res_invalid_o, exp_inv, $sformatf("res_invalid_o for eva %h", exp_eva));
        seen_cnt++;
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit_lp) begin
      $display("simulation timed out before all checks finished");
      $display("TEST FAILED");
      $fatal(1, "cycle limit reached");
    end
  end

  initial begin
    stim_s       s;
    logic [31:0] r;
    seed       = 32'h450f_dbd4;
    rst_i      = 1'b1;
    cfg_we_i   = 1'b0;
    cfg_data_i = '0;
    req_i      = 1'b0;
    eva_i      = '0;
    model_cfg  = '0;
    req_seen   = 1'b0;
    sent_cnt   = 0;
    seen_cnt   = 0;
    cycle_cnt  = 0;
    fill_table();
    repeat (4) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    check_flag(res_v_o, 1'b0, "res_v_o after reset");
    check_flag(res_invalid_o, 1'b0, "res_invalid_o after reset");
    for (int i = 0; i < num_entries_lp; i++) begin
      apply_entry(stim_table[i]);
    end
    // random dram and global, fresh pod every 8 draws
    for (int i = 0; i < num_random_lp; i++) begin
      r        = $random(seed);
      s.cfg_we = (i % 8 == 0);
      s.cfg    = r[13:0];
      r        = $random(seed);
      s.eva    = i[0] ? {1'b1, r[30:0]} : {2'b01, r[29:0]};
      s.b2b    = r[31];
      apply_entry(s);
    end
    // last result lands one cycle after its request
    repeat (2) @(posedge clk_i);
    #1;
    if (seen_cnt == sent_cnt) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("saw %0d results for %0d requests", seen_cnt, sent_cnt);
      $display("TEST FAILED");
      $fatal(1, "result count mismatch");
    end
  end

endmodule

// ==== design/npa_xlate_top.sv ====
// endpoint address path top, config register feeding the eva translator and the result register
`timescale 1ns/1ps

module npa_xlate_top #(
  parameter int num_vcache_rows_p = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       cfg_we_i,
  input  eva_npa_pkg::endpoint_cfg_s cfg_data_i,
  input  logic                       req_i,
  input  eva_npa_pkg::eva_t          eva_i,
  output logic                       res_v_o,
  output eva_npa_pkg::npa_s          res_o,
  output logic                       res_invalid_o
);

  eva_npa_pkg::endpoint_cfg_s cfg;
  eva_npa_pkg::npa_s          npa;
  logic                       invalid;

  // origin and pod coordinates
  endpoint_cfg u_cfg (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .we_i  (cfg_we_i),
    .data_i(cfg_data_i),
    .cfg_o (cfg)
  );

  // translation is purely combinational
  eva_to_npa #(
    .num_vcache_rows_p(num_vcache_rows_p)
  ) u_xlate (
    .eva_i    (eva_i),
    .cfg_i    (cfg),
    .npa_o    (npa),
    .invalid_o(invalid)
  );

  // single register stage, result lands one cycle after req
  npa_issue_reg u_issue (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (req_i),
    .npa_i        (npa),
    .invalid_i    (invalid),
    .res_v_o      (res_v_o),
    .res_o        (res_o),
    .res_invalid_o(res_invalid_o)
  );

endmodule

// ==== design/npa_issue_reg.sv ====
// output stage that registers a translated npa and pulses the result valid one cycle after a request
`timescale 1ns/1ps

module npa_issue_reg (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              req_i,
  input  eva_npa_pkg::npa_s npa_i,
  input  logic              invalid_i,
  output logic              res_v_o,
  output eva_npa_pkg::npa_s res_o,
  output logic              res_invalid_o
);

  logic              res_v_r;
  logic              res_invalid_r;
  eva_npa_pkg::npa_s npa_r;

  // valid follows the request strobe with one cycle delay
  // back-to-back requests keep it high
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_v_r <= 1'b0;
    end else begin
      res_v_r <= req_i;
    end
  end

  // invalid flag is control, cleared on reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      res_invalid_r <= 1'b0;
    end else if (req_i) begin
      res_invalid_r <= invalid_i;
    end
  end

  // payload only loads on a request, holds otherwise
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      npa_r <= npa_i;
    end
  end

  assign res_v_o       = res_v_r;
  assign res_invalid_o = res_invalid_r;
  assign res_o         = npa_r;

endmodule

// ==== design/endpoint_cfg.sv ====
// config register for tile-group origin and pod coordinates, loaded by a write strobe
`timescale 1ns/1ps

module endpoint_cfg (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       we_i,
  input  eva_npa_pkg::endpoint_cfg_s data_i,
  output eva_npa_pkg::endpoint_cfg_s cfg_o
);

  eva_npa_pkg::endpoint_cfg_s cfg_r;

  // origin and pod both come up at zero
  // a write is visible the cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cfg_r <= '0;
    end else if (we_i) begin
      cfg_r <= data_i;
    end
  end

  // translator reads the fields straight from the flops
  assign cfg_o = cfg_r;

endmodule

// ==== design/eva_to_npa.sv ====
// combinational classifier that maps an endpoint virtual address to a network physical address
`timescale 1ns/1ps

module eva_to_npa #(
  parameter int num_vcache_rows_p = 1
) (
  input  eva_npa_pkg::eva_t          eva_i,
  input  eva_npa_pkg::endpoint_cfg_s cfg_i,
  output eva_npa_pkg::npa_s          npa_o,
  output logic                       invalid_o
);

  eva_npa_pkg::global_eva_s     global_eva;
  eva_npa_pkg::tile_group_eva_s tg_eva;
  logic                         is_dram;
  logic                         is_global;
  logic                         is_tile_group;
  logic                         in_overflow;

  // overlay both layouts on the raw eva
  assign global_eva = eva_i;
  assign tg_eva     = eva_i;

  assign is_dram       = eva_i[eva_npa_pkg::eva_width_gp-1];
  assign is_global     = global_eva.remote == eva_npa_pkg::global_tag_gp;
  assign is_tile_group = tg_eva.remote == eva_npa_pkg::tile_group_tag_gp;
  assign in_overflow   = (tg_eva.addr >= eva_npa_pkg::overflow_lo_gp)
                      && (tg_eva.addr <= eva_npa_pkg::overflow_hi_gp);

  // plain dram hash on the raw eva
  eva_npa_pkg::npa_s dram_npa;

  dram_hash #(
    .num_vcache_rows_p(num_vcache_rows_p)
  ) u_dram_hash (
    .eva_i   (eva_i),
    .pod_x_i (cfg_i.pod_x),
    .pod_y_i (cfg_i.pod_y),
    .x_cord_o(dram_npa.x_cord),
    .y_cord_o(dram_npa.y_cord),
    .epa_o   (dram_npa.epa)
  );

  // overflowed dmem access gets reshuffled into a dram eva
  eva_npa_pkg::eva_t ovf_eva;

  assign ovf_eva[31] = 1'b1;
  // untouched fields
  assign ovf_eva[5:0]   = eva_i[5:0];
  assign ovf_eva[17:15] = eva_i[17:15];
  assign ovf_eva[25:22] = eva_i[25:22];
  assign ovf_eva[30:27] = eva_i[30:27];
  // rotate column, index and x fields
  assign ovf_eva[9:6]   = eva_i[21:18];
  assign ovf_eva[21:18] = eva_i[14:11];
  assign ovf_eva[14:11] = eva_i[9:6];
  // exchange north/south select with a high bit
  assign ovf_eva[10] = eva_i[26];
  assign ovf_eva[26] = eva_i[10];

  eva_npa_pkg::npa_s ovf_npa;

  dram_hash #(
    .num_vcache_rows_p(num_vcache_rows_p)
  ) u_ovf_hash (
    .eva_i   (ovf_eva),
    .pod_x_i (cfg_i.pod_x),
    .pod_y_i (cfg_i.pod_y),
    .x_cord_o(ovf_npa.x_cord),
    .y_cord_o(ovf_npa.y_cord),
    .epa_o   (ovf_npa.epa)
  );

  // tile-group offset from origin, wraps inside the pod
  eva_npa_pkg::x_sub_t tg_x_sub;
  eva_npa_pkg::y_sub_t tg_y_sub;

  assign tg_x_sub = tg_eva.x_cord[eva_npa_pkg::x_sub_width_gp-1:0] + cfg_i.tgo_x;
  assign tg_y_sub = tg_eva.y_cord[eva_npa_pkg::y_sub_width_gp-1:0] + cfg_i.tgo_y;

  // priority: dram, global, overflow window, tile-group, invalid
  always_comb begin
    npa_o     = '0;
    invalid_o = 1'b0;
    if (is_dram) begin
      npa_o = dram_npa;
    end else if (is_global) begin
      npa_o.x_cord = global_eva.x_cord;
      npa_o.y_cord = global_eva.y_cord;
      npa_o.epa    = eva_npa_pkg::epa_t'(global_eva.addr);
    end else if (is_tile_group) begin
      if (in_overflow) begin
        npa_o = ovf_npa;
      end else begin
        npa_o.x_cord = {cfg_i.pod_x, tg_x_sub};
        npa_o.y_cord = {cfg_i.pod_y, tg_y_sub};
        // keep only the dmem word range
        npa_o.epa    = eva_npa_pkg::epa_t'(tg_eva.addr[eva_npa_pkg::tg_epa_width_gp-1:0]);
      end
    end else begin
      // top bits 000, nothing maps here
      invalid_o = 1'b1;
    end
  end

endmodule

// ==== design/dram_hash.sv ====
// combinational stripe of a dram eva across the north and south vcache rows of a pod
`timescale 1ns/1ps

module dram_hash #(
  parameter int num_vcache_rows_p = 1
) (
  input  eva_npa_pkg::eva_t     eva_i,
  input  eva_npa_pkg::pod_x_t   pod_x_i,
  input  eva_npa_pkg::pod_y_t   pod_y_i,
  output eva_npa_pkg::x_cord_t  x_cord_o,
  output eva_npa_pkg::y_cord_t  y_cord_o,
  output eva_npa_pkg::epa_t     epa_o
);

  // word address drops the byte offset and the dram flag
  localparam int word_width_lp   = eva_npa_pkg::eva_width_gp - 3;
  localparam int offset_width_lp = $clog2(eva_npa_pkg::vcache_block_words_gp);
  localparam int col_width_lp    = eva_npa_pkg::x_sub_width_gp;
  // lsb of the selector is north/south, the rest is the row inside that side
  localparam int row_id_width_lp = $clog2(2 * num_vcache_rows_p);
  localparam int row_k_width_lp  = (row_id_width_lp > 1) ? row_id_width_lp - 1 : 1;
  localparam int set_lsb_lp      = offset_width_lp + col_width_lp + row_id_width_lp;
  localparam int set_width_lp    = word_width_lp - set_lsb_lp;

  logic [word_width_lp-1:0]   word_addr;
  logic [offset_width_lp-1:0] word_offset;
  eva_npa_pkg::x_sub_t        col;
  logic [row_id_width_lp-1:0] row_sel;
  logic [row_k_width_lp-1:0]  row_k;
  logic                       is_south;
  logic [set_width_lp-1:0]    set_idx;
  eva_npa_pkg::pod_y_t        north_pod_y;
  eva_npa_pkg::pod_y_t        south_pod_y;
  eva_npa_pkg::y_sub_t        north_y_sub;
  eva_npa_pkg::y_sub_t        south_y_sub;

  assign word_addr = eva_i[eva_npa_pkg::eva_width_gp-2:2];

  // slice the word address, lowest field first
  assign word_offset = word_addr[offset_width_lp-1:0];
  assign col         = word_addr[offset_width_lp+col_width_lp-1:offset_width_lp];
  assign row_sel     = word_addr[set_lsb_lp-1:offset_width_lp+col_width_lp];
  assign set_idx     = word_addr[word_width_lp-1:set_lsb_lp];

  assign is_south = row_sel[0];
  // with a single row per side this shifts down to zero
  assign row_k    = row_k_width_lp'(row_sel >> 1);

  // vcache rows sit in the pods just above and below, wrapping mod 16
  assign north_pod_y = pod_y_i - 1'b1;
  assign south_pod_y = pod_y_i + 1'b1;

  // north rows count up from the bottom edge, inner row first
  assign north_y_sub = eva_npa_pkg::y_sub_t'(eva_npa_pkg::num_tiles_y_gp - 1 - int'(row_k));
  assign south_y_sub = eva_npa_pkg::y_sub_t'(row_k);

  assign x_cord_o = {pod_x_i, col};

  always_comb begin
    if (is_south) begin
      y_cord_o = {south_pod_y, south_y_sub};
    end else begin
      y_cord_o = {north_pod_y, north_y_sub};
    end
  end

  // set index over line offset, zero padded
  assign epa_o = eva_npa_pkg::epa_t'({set_idx, word_offset});

endmodule

// ==== design/eva_npa_pkg.sv ====
// shared eva field layouts, npa types and structs, referenced by scoped name across the address path
package eva_npa_pkg;

  // mesh geometry inside one pod
  localparam int num_tiles_x_gp = 16;
  localparam int num_tiles_y_gp = 8;

  // vcache line size in words
  localparam int vcache_block_words_gp = 16;

  // field widths
  localparam int eva_width_gp   = 32;
  localparam int x_sub_width_gp = $clog2(num_tiles_x_gp);
  localparam int y_sub_width_gp = $clog2(num_tiles_y_gp);
  localparam int pod_x_width_gp = 3;
  localparam int pod_y_width_gp = 4;
  localparam int epa_width_gp   = 28;

  // tile dmem holds 1k words so a tile-group epa keeps only this many bits
  localparam int tg_epa_width_gp = 10;

  // remote tags in the top bits of a non-dram eva
  localparam logic [1:0] global_tag_gp     = 2'b01;
  localparam logic [2:0] tile_group_tag_gp = 3'b001;

  // tile-group addresses in this range spill into dram
  localparam logic [15:0] overflow_lo_gp = 16'h0100;
  localparam logic [15:0] overflow_hi_gp = 16'hFCFF;

  typedef logic [eva_width_gp-1:0]   eva_t;
  typedef logic [pod_x_width_gp-1:0] pod_x_t;
  typedef logic [pod_y_width_gp-1:0] pod_y_t;
  typedef logic [x_sub_width_gp-1:0] x_sub_t;
  typedef logic [y_sub_width_gp-1:0] y_sub_t;
  // global x is pod x over x sub
  // global y is pod y over y sub
  typedef logic [pod_x_width_gp+x_sub_width_gp-1:0] x_cord_t;
  typedef logic [pod_y_width_gp+y_sub_width_gp-1:0] y_cord_t;
  typedef logic [epa_width_gp-1:0] epa_t;

  // global eva carries its coordinates directly
  typedef struct packed {
    logic [1:0]  remote;
    y_cord_t     y_cord;
    x_cord_t     x_cord;
    logic [15:0] addr;
  } global_eva_s;

  // tile-group eva with coordinates relative to the group origin
  typedef struct packed {
    logic [2:0]  remote;
    logic [5:0]  y_cord;
    logic [6:0]  x_cord;
    logic [15:0] addr;
  } tile_group_eva_s;

  // network physical address
  typedef struct packed {
    x_cord_t x_cord;
    y_cord_t y_cord;
    epa_t    epa;
  } npa_s;

  // per-endpoint config whose origin is relative to the pod
  typedef struct packed {
    x_sub_t tgo_x;
    y_sub_t tgo_y;
    pod_x_t pod_x;
    pod_y_t pod_y;
  } endpoint_cfg_s;

endpackage
